/* Makefile */
TOP := rider_status_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* build.f */
+incdir+common
common/rider_pkg.sv
design/soft_error_counter.sv
status/status_reg_block.sv
status/status_axil_slave.sv
design/rider_status_top.sv
sim/tb_clk_gen.sv
sim/rider_status_assert.sv
sim/rider_status_tb.sv

/* common/rider_macros.svh */
`ifndef RIDER_MACROS_SVH
`define RIDER_MACROS_SVH

// Firmware revision, packed into status word 0
`define RIDER_MAJOR_REV 8'd3
`define RIDER_MINOR_REV 8'd1
`define RIDER_PATCH_REV 8'd7

`define RIDER_CNT_W 32     // Soft-error count and threshold width
`define RIDER_N_SOFT 3     // Number of soft-error sources
`define RIDER_N_STATUS 13  // Status words on the read side

// Writable byte addresses
`define RIDER_ADDR_THRES0 8'h40  // Data corruption threshold
`define RIDER_ADDR_THRES1 8'h44  // Unknown TTC command threshold
`define RIDER_ADDR_THRES2 8'h48  // DDR3 overflow threshold
`define RIDER_ADDR_CLEAR 8'h4C   // Counter clear mask in wdata[2:0]

`endif

/* common/rider_pkg.sv */
`include "rider_macros.svh"

package rider_pkg;

  // Index of each soft-error source
  typedef enum logic [1:0] {
    SRC_DATA_CORRUPT  = 2'd0,
    SRC_UNKNOWN_TTC   = 2'd1,
    SRC_DDR3_OVERFLOW = 2'd2
  } soft_src_e;

  // Word k sits at byte address 4k
  typedef logic [`RIDER_N_STATUS-1:0][31:0] status_bus_t;

  // Field view of status word 1
  typedef struct packed {
    logic [21:0] zero;        // Unused upper bits
    logic [4:0]  chan_error;  // Per-channel error flags
    logic        ddr3_overflow;
    logic        data_corrupt;
    logic        trig_rate;
    logic        unknown_ttc;
    logic        pll_unlock;  // Bit 0
  } error_fields_t;

  // Error word, seen either raw or by field
  typedef union packed {
    logic [31:0]   raw;
    error_fields_t f;
  } error_word_u;

endpackage

/* design/rider_status_top.sv */
`timescale 1ns/1ps
`include "rider_macros.svh"

// Channel board status and soft-error monitor
module rider_status_top (
  input  logic                     clk,
  input  logic                     arst_n,

  // AXI4-Lite host port
  input  logic [7:0]               awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [7:0]               araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,

  // Board status inputs
  input  logic                     pll_unlock,
  input  logic                     trig_rate_err,
  input  logic [4:0]               chan_error,
  input  logic                     prog_chan_done,
  input  logic                     async_mode,
  input  logic [11:0]              i2c_temp,
  input  logic                     daq_clk_sel,
  input  logic                     daq_clk_en,
  input  logic [3:0]               tts_state,
  input  logic [5:0]               ttc_chan_b_info,
  input  logic                     ttc_ready,
  input  logic [23:0]              trig_num,
  input  logic [43:0]              trig_timestamp,
  input  logic [`RIDER_N_SOFT-1:0] soft_event   // One pulse per soft error
);

  logic [`RIDER_N_SOFT*`RIDER_CNT_W-1:0]     thres;
  logic [`RIDER_N_SOFT-1:0]                  clr;
  logic [`RIDER_N_SOFT-1:0][`RIDER_CNT_W-1:0] count;
  logic [`RIDER_N_SOFT-1:0]                  over_thres;
  rider_pkg::status_bus_t                    status_words;

  status_axil_slave u_slave (
    .clk          (clk),
    .arst_n       (arst_n),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .status_words (status_words),
    .thres        (thres),
    .clr          (clr)
  );

  // One counter per soft-error source
  for (genvar i = 0; i < `RIDER_N_SOFT; i++) begin : g_cnt
    localparam rider_pkg::soft_src_e SRC = rider_pkg::soft_src_e'(i);

    soft_error_counter u_cnt (
      .clk        (clk),
      .arst_n     (arst_n),
      .evt        (soft_event[SRC]),
      .clr        (clr[SRC]),
      .thres      (thres[SRC*`RIDER_CNT_W +: `RIDER_CNT_W]),
      .count      (count[SRC]),
      .over_thres (over_thres[SRC])
    );
  end

  status_reg_block u_status (
    .count_data_corrupt  (count[rider_pkg::SRC_DATA_CORRUPT]),
    .count_unknown_ttc   (count[rider_pkg::SRC_UNKNOWN_TTC]),
    .count_ddr3_overflow (count[rider_pkg::SRC_DDR3_OVERFLOW]),
    .thres               (thres),
    .over_thres          (over_thres),
    .pll_unlock          (pll_unlock),
    .trig_rate_err       (trig_rate_err),
    .chan_error          (chan_error),
    .prog_chan_done      (prog_chan_done),
    .async_mode          (async_mode),
    .i2c_temp            (i2c_temp),
    .daq_clk_sel         (daq_clk_sel),
    .daq_clk_en          (daq_clk_en),
    .tts_state           (tts_state),
    .ttc_chan_b_info     (ttc_chan_b_info),
    .ttc_ready           (ttc_ready),
    .trig_num            (trig_num),
    .trig_timestamp      (trig_timestamp),
    .status_words        (status_words)
  );

endmodule

/* design/soft_error_counter.sv */
`timescale 1ns/1ps
`include "rider_macros.svh"

// One soft-error source
// Saturating event count plus a threshold compare
module soft_error_counter (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    evt,         // One-cycle soft-error pulse
  input  logic                    clr,         // One-cycle clear pulse
  input  logic [`RIDER_CNT_W-1:0] thres,       // Hard-error threshold
  output logic [`RIDER_CNT_W-1:0] count,       // Events since last clear
  output logic                    over_thres   // Count above threshold
);

  logic cnt_full;  // Count at all ones
  logic cnt_inc;

  assign cnt_full = &count;
  assign cnt_inc  = evt & ~cnt_full;  // Hold at max

  // Count register
  // Clear has priority over a same-cycle event
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (clr) begin
      count <= '0;  // Event in this cycle is dropped
    end else if (cnt_inc) begin
      count <= count + 1'b1;
    end
  end

  // Hard error once the count passes its threshold
  // Threshold of zero trips on the first event
  assign over_thres = (count > thres);

endmodule

/* sim/rider_status_assert.sv */
`timescale 1ns/1ps

// AXI handshake and clear pulse properties
module rider_status_assert (
  input logic       clk,
  input logic       arst_n,
  input logic       awvalid,
  input logic       awready,
  input logic       wvalid,
  input logic       wready,
  input logic       bvalid,
  input logic       bready,
  input logic       arvalid,
  input logic       arready,
  input logic       rvalid,
  input logic       rready,
  input logic [2:0] clr
);

  // Valid held until its handshake
  a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
    awvalid && !awready |=> awvalid) else $error("awvalid dropped early");
  a_w_hold: assert property (@(posedge clk) disable iff (!arst_n)
    wvalid && !wready |=> wvalid) else $error("wvalid dropped early");
  a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
    arvalid && !arready |=> arvalid) else $error("arvalid dropped early");
  a_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped early");
  a_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped early");

  // Clear is a single-cycle pulse
  a_clr_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    (|clr) |=> (clr == 3'd0)) else $error("clr high two cycles in a row");

  // Response only after a write transfer
  a_b_cause: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
    else $error("bvalid without write handshake");

endmodule

bind rider_status_top rider_status_assert u_assert (
  .clk     (clk),
  .arst_n  (arst_n),
  .awvalid (awvalid),
  .awready (awready),
  .wvalid  (wvalid),
  .wready  (wready),
  .bvalid  (bvalid),
  .bready  (bready),
  .arvalid (arvalid),
  .arready (arready),
  .rvalid  (rvalid),
  .rready  (rready),
  .clr     (clr)
);

/* sim/rider_status_tb.sv */
`timescale 1ns/1ps
`include "rider_macros.svh"

module rider_status_tb;

  localparam int WAIT_LIMIT = 50;  // Cycles per handshake wait

  logic clk, arst_n;
  logic [7:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [31:0] wdata, rdata;
  logic [3:0] wstrb;
  logic [1:0] bresp, rresp;
  logic pll_unlock, trig_rate_err, prog_chan_done, async_mode;
  logic daq_clk_sel, daq_clk_en, ttc_ready;
  logic [4:0] chan_error;
  logic [11:0] i2c_temp;
  logic [3:0] tts_state;
  logic [5:0] ttc_chan_b_info;
  logic [23:0] trig_num;
  logic [43:0] trig_timestamp;
  logic [2:0] soft_event;

  logic [31:0] thr_exp [3];  // Thresholds as written
  logic [31:0] cnt_exp [3];  // Events seen per source
  integer seed;
  int errors, checks;
  bit reported;

  tb_clk_gen u_clk (.clk(clk));

  rider_status_top u_dut (.*);

  // Expected status word k from driven inputs and tracked state
  function automatic logic [31:0] pack_status(input int k);
    rider_pkg::error_word_u ew;
    logic [31:0] w;
    ew = '0;
    ew.f.pll_unlock    = pll_unlock;
    ew.f.unknown_ttc   = cnt_exp[1] > thr_exp[1];
    ew.f.trig_rate     = trig_rate_err;
    ew.f.data_corrupt  = cnt_exp[0] > thr_exp[0];
    ew.f.ddr3_overflow = cnt_exp[2] > thr_exp[2];
    ew.f.chan_error    = chan_error;
    case (k)
      0: w = {1'b0, prog_chan_done, async_mode, 5'd0,
              `RIDER_MAJOR_REV, `RIDER_MINOR_REV, `RIDER_PATCH_REV};
      1: w = ew.raw;
      2: w = {i2c_temp, 18'd0, daq_clk_sel, daq_clk_en};
      3: w = {21'd0, tts_state, ttc_chan_b_info, ttc_ready};
      4: w = {8'd0, trig_num};
      5: w = trig_timestamp[31:0];
      6: w = {20'd0, trig_timestamp[43:32]};
      7, 9, 11: w = thr_exp[(k - 7) / 2];   // Threshold of source
      8, 10, 12: w = cnt_exp[(k - 8) / 2];  // Count of source
      default: w = 32'd0;
    endcase
    return w;
  endfunction

  // Byte-strobe merge of a register write
  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] strb);
    logic [31:0] m;
    m = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) m[8*b +: 8] = data[8*b +: 8];
    end
    return m;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    reported = 1'b1;
    $finish;
  endtask

  // Single AXI read, starts and ends just after a rising edge
  // rready held low for one cycle once rvalid is up
  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!arready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!arready) abort_run("timeout waiting for arready");
    @(posedge clk);  // AR handshake
    #1;
    arvalid = 1'b0;
    n = 0;
    @(negedge clk);
    while (!rvalid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!rvalid) abort_run("timeout waiting for rvalid");
    @(posedge clk);  // One cycle of back-pressure
    #1;
    rready = 1'b1;
    @(negedge clk);
    data = rdata;  // Word held since the AR handshake
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // Single AXI write, AW and W together
  // bready held low for one cycle once bvalid is up
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    @(negedge clk);
    while (!(awready && wready) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!(awready && wready)) abort_run("timeout waiting for awready and wready");
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    @(negedge clk);
    while (!bvalid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!bvalid) abort_run("timeout waiting for bvalid");
    @(posedge clk);  // One cycle of back-pressure
    #1;
    bready = 1'b1;
    @(negedge clk);
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic read_check(input int k);
    logic [31:0] data;
    logic [1:0] resp;
    axil_read(8'(4 * k), data, resp);
    check_value($sformatf("word%0d", k), pack_status(k), data);
    check_value($sformatf("word%0d rresp", k), 32'd0, {30'd0, resp});
  endtask

  task automatic drive_board_random();
    logic [31:0] r;
    logic [31:0] r2;
    @(posedge clk);
    #1;
    r  = $random(seed);
    r2 = $random(seed);
    {pll_unlock, trig_rate_err, prog_chan_done, async_mode} = r[3:0];
    {daq_clk_sel, daq_clk_en, ttc_ready} = r[6:4];
    chan_error      = r[11:7];
    tts_state       = r[15:12];
    ttc_chan_b_info = r[21:16];
    i2c_temp        = r2[11:0];
    trig_num        = r2[31:8];
    r = $random(seed);
    trig_timestamp  = {r2[11:0], r};
  endtask

  initial begin
    logic [31:0] r, data;
    logic [1:0] resp;
    int ncyc;
    seed = 32'h3e29;
    errors = 0;
    checks = 0;
    reported = 1'b0;
    arst_n = 1'b0;
    {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
    {araddr, arvalid, rready} = '0;
    {pll_unlock, trig_rate_err, prog_chan_done, async_mode} = '0;
    {daq_clk_sel, daq_clk_en, ttc_ready, chan_error, i2c_temp} = '0;
    {tts_state, ttc_chan_b_info, trig_num, trig_timestamp} = '0;
    soft_event = '0;
    for (int s = 0; s < 3; s++) begin
      thr_exp[s] = '0;
      cnt_exp[s] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Reset values
    read_check(0);
    for (int k = 7; k <= 12; k++) begin
      axil_read(8'(4 * k), data, resp);
      check_value($sformatf("reset word%0d", k), 32'd0, data);
    end

    // Board status packing
    repeat (4) begin
      drive_board_random();
      for (int k = 0; k <= 6; k++) read_check(k);
    end

    // Threshold write, full then partial strobe
    r = $random(seed);
    axil_write(`RIDER_ADDR_THRES0, r, 4'hF, resp);
    check_value("thres full bresp", 32'd0, {30'd0, resp});
    thr_exp[0] = r;
    r = $random(seed);
    axil_write(`RIDER_ADDR_THRES0, r, 4'b0101, resp);
    thr_exp[0] = merge_bytes(thr_exp[0], r, 4'b0101);
    read_check(7);
    r = $random(seed);
    axil_write(`RIDER_ADDR_THRES1, r, 4'b1010, resp);
    thr_exp[1] = merge_bytes(thr_exp[1], r, 4'b1010);
    read_check(9);

    // Small thresholds, then random event bursts
    for (int s = 0; s < 3; s++) begin
      r = $random(seed);
      axil_write(8'(`RIDER_ADDR_THRES0 + 4 * s), {28'd0, r[3:0]}, 4'hF, resp);
      thr_exp[s] = {28'd0, r[3:0]};
    end
    r = $random(seed);
    ncyc = 8 + int'(r[3:0]);
    repeat (ncyc) begin
      @(posedge clk);
      #1;
      r = $random(seed);
      soft_event = r[2:0];
      for (int s = 0; s < 3; s++) begin
        if (r[s]) cnt_exp[s] = cnt_exp[s] + 32'd1;  // Counted at next edge
      end
    end
    @(posedge clk);
    #1;
    soft_event = '0;
    for (int k = 7; k <= 12; k++) read_check(k);
    read_check(1);

    // Masked clear
    axil_write(`RIDER_ADDR_CLEAR, 32'd5, 4'hF, resp);
    check_value("clear bresp", 32'd0, {30'd0, resp});
    cnt_exp[0] = '0;
    cnt_exp[2] = '0;
    for (int k = 8; k <= 12; k += 2) read_check(k);
    read_check(1);

    // Unmapped accesses
    axil_read(8'h34, data, resp);
    check_value("bad read rresp", 32'd2, {30'd0, resp});
    check_value("bad read rdata", 32'd0, data);
    axil_write(8'h00, 32'hFFFF_FFFF, 4'hF, resp);
    check_value("bad write bresp", 32'd2, {30'd0, resp});
    for (int k = 0; k < `RIDER_N_STATUS; k++) read_check(k);

    $display("checks %0d errors %0d", checks, errors);
    reported = 1'b1;
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Run stopped before the closing report
  final begin
    if (!reported) $display("Some tests failed");
  end

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

// Free-running testbench clock
module tb_clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;  // 10 ns period

endmodule

/* status/status_axil_slave.sv */
`timescale 1ns/1ps
`include "rider_macros.svh"

// AXI4-Lite register slave
// Reads the status words, writes thresholds and counter clears
module status_axil_slave (
  input  logic                                 clk,
  input  logic                                 arst_n,

  // Write address
  input  logic [7:0]                           awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,

  // Write data
  input  logic [31:0]                          wdata,
  input  logic [3:0]                           wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,

  // Write response
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,

  // Read address
  input  logic [7:0]                           araddr,
  input  logic                                 arvalid,
  output logic                                 arready,

  // Read data
  output logic [31:0]                          rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready,

  input  rider_pkg::status_bus_t               status_words,
  output logic [`RIDER_N_SOFT*`RIDER_CNT_W-1:0] thres,  // To counters and status block
  output logic [`RIDER_N_SOFT-1:0]             clr     // One-cycle clear pulse
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic                                    wr_rdy;     // Shared AW/W ready
  logic                                    wr_hs;      // AW and W transfer
  logic                                    rd_hs;      // AR transfer
  logic [`RIDER_N_SOFT-1:0]                thres_sel;  // Threshold write target
  logic                                    clr_sel;    // Clear address hit
  logic                                    wr_ok;
  logic [5:0]                              rd_idx;     // Word index from araddr
  logic                                    rd_ok;
  logic [`RIDER_N_SOFT-1:0][`RIDER_CNT_W-1:0] thres_q;

  assign awready = wr_rdy;
  assign wready  = wr_rdy;
  assign wr_hs   = wr_rdy & awvalid & wvalid;
  assign rd_hs   = arready & arvalid;
  assign thres   = thres_q;

  // Write address decode
  always_comb begin
    thres_sel = '0;
    clr_sel   = 1'b0;
    case (awaddr)
      `RIDER_ADDR_THRES0: thres_sel[rider_pkg::SRC_DATA_CORRUPT]  = 1'b1;
      `RIDER_ADDR_THRES1: thres_sel[rider_pkg::SRC_UNKNOWN_TTC]   = 1'b1;
      `RIDER_ADDR_THRES2: thres_sel[rider_pkg::SRC_DDR3_OVERFLOW] = 1'b1;
      `RIDER_ADDR_CLEAR:  clr_sel = 1'b1;
      default: ;  // Unmapped, answered with SLVERR
    endcase
  end

  assign wr_ok = (|thres_sel) | clr_sel;

  // Read decode, words 0 to 12 only
  assign rd_idx = araddr[7:2];
  assign rd_ok  = (rd_idx < 6'(`RIDER_N_STATUS));

  // Write handshake and response
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_rdy <= 1'b0;
      bvalid <= 1'b0;
      clr    <= '0;
    end else begin
      // Ready for one cycle once both channels are valid
      wr_rdy <= ~wr_rdy & awvalid & wvalid & ~bvalid;
      clr    <= '0;  // Pulse lasts one cycle
      if (wr_hs) begin
        bvalid <= 1'b1;
        if (clr_sel) begin
          clr <= wdata[`RIDER_N_SOFT-1:0];
        end
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Threshold registers, byte by byte
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      thres_q <= '0;
    end else if (wr_hs) begin
      for (int s = 0; s < `RIDER_N_SOFT; s++) begin
        for (int b = 0; b < 4; b++) begin
          if (thres_sel[s] && wstrb[b]) begin
            thres_q[s][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Read handshake
  // arready low while a response waits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else if (rd_hs) begin
      arready <= 1'b0;
      rvalid  <= 1'b1;
    end else if (rvalid && rready) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
    end else if (!rvalid) begin
      arready <= 1'b1;  // First cycle out of reset
    end
  end

  // Response payloads, held until their handshakes
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      rdata <= rd_ok ? status_words[rd_idx[3:0]] : 32'd0;  // Sampled at AR
    end
    if (wr_hs) begin
      bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

/* status/status_reg_block.sv */
`timescale 1ns/1ps
`include "rider_macros.svh"

// Status word packing
// Pure combinational, read through the AXI slave
module status_reg_block (
  // Soft-error counts
  input  logic [`RIDER_CNT_W-1:0]              count_data_corrupt,
  input  logic [`RIDER_CNT_W-1:0]              count_unknown_ttc,
  input  logic [`RIDER_CNT_W-1:0]              count_ddr3_overflow,

  // Thresholds and hard errors, indexed by source
  input  logic [`RIDER_N_SOFT*`RIDER_CNT_W-1:0] thres,
  input  logic [`RIDER_N_SOFT-1:0]             over_thres,

  // Other error inputs
  input  logic                                 pll_unlock,
  input  logic                                 trig_rate_err,
  input  logic [4:0]                           chan_error,

  // FPGA status
  input  logic                                 prog_chan_done,
  input  logic                                 async_mode,

  // Temperature and external clock
  input  logic [11:0]                          i2c_temp,
  input  logic                                 daq_clk_sel,
  input  logic                                 daq_clk_en,

  // TTC/TTS
  input  logic [3:0]                           tts_state,
  input  logic [5:0]                           ttc_chan_b_info,
  input  logic                                 ttc_ready,

  // Trigger
  input  logic [23:0]                          trig_num,
  input  logic [43:0]                          trig_timestamp,

  output rider_pkg::status_bus_t               status_words
);

  rider_pkg::error_word_u err_word;  // Word 1

  logic [`RIDER_CNT_W-1:0] thres_data_corrupt;
  logic [`RIDER_CNT_W-1:0] thres_unknown_ttc;
  logic [`RIDER_CNT_W-1:0] thres_ddr3_overflow;

  // Split the threshold bus by source
  assign thres_data_corrupt  = thres[rider_pkg::SRC_DATA_CORRUPT*`RIDER_CNT_W +: `RIDER_CNT_W];
  assign thres_unknown_ttc   = thres[rider_pkg::SRC_UNKNOWN_TTC*`RIDER_CNT_W +: `RIDER_CNT_W];
  assign thres_ddr3_overflow = thres[rider_pkg::SRC_DDR3_OVERFLOW*`RIDER_CNT_W +: `RIDER_CNT_W];

  // Error word built field by field
  always_comb begin
    err_word                 = '0;  // Upper bits stay zero
    err_word.f.pll_unlock    = pll_unlock;
    err_word.f.unknown_ttc   = over_thres[rider_pkg::SRC_UNKNOWN_TTC];
    err_word.f.trig_rate     = trig_rate_err;
    err_word.f.data_corrupt  = over_thres[rider_pkg::SRC_DATA_CORRUPT];
    err_word.f.ddr3_overflow = over_thres[rider_pkg::SRC_DDR3_OVERFLOW];
    err_word.f.chan_error    = chan_error;
  end

  // Word 0 FPGA status and firmware revision
  assign status_words[0] = {1'b0, prog_chan_done, async_mode, 5'd0,
                            `RIDER_MAJOR_REV, `RIDER_MINOR_REV, `RIDER_PATCH_REV};

  assign status_words[1] = err_word.raw;  // Hard errors

  // Temperature on top, clock select and enable at the bottom
  assign status_words[2] = {i2c_temp, 18'd0, daq_clk_sel, daq_clk_en};

  // TTS state, channel B info, TTC ready
  assign status_words[3] = {21'd0, tts_state, ttc_chan_b_info, ttc_ready};

  assign status_words[4] = {8'd0, trig_num};                 // Trigger number
  assign status_words[5] = trig_timestamp[31:0];              // Timestamp LSB
  assign status_words[6] = {20'd0, trig_timestamp[43:32]};    // Timestamp MSB

  // Threshold and count pairs
  assign status_words[7]  = thres_data_corrupt;
  assign status_words[8]  = count_data_corrupt;
  assign status_words[9]  = thres_unknown_ttc;
  assign status_words[10] = count_unknown_ttc;
  assign status_words[11] = thres_ddr3_overflow;
  assign status_words[12] = count_ddr3_overflow;

endmodule
